//--- signedMultiplier.f
+incdir+hdl
hdl/mulPkg.sv
hdl/hexDriver.sv
hdl/shiftReg.sv
hdl/addSub9.sv
hdl/mulControl.sv
hdl/signedMultiplier.sv
dv/signedMultiplierTb.sv

//--- Bender.yml
package:
  name: signed_multiplier

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mulPkg.sv
      - hdl/hexDriver.sv
      - hdl/shiftReg.sv
      - hdl/addSub9.sv
      - hdl/mulControl.sv
      - hdl/signedMultiplier.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/signedMultiplierTb.sv

//--- dv/signedMultiplierTb.sv
`include "mul_params.svh"

// Testbench for the signed shift-and-add multiplier
// A model of A, B and X is kept in step with the stimulus and compared at each check
module signedMultiplierTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ResetCycles = 5;
	// Clear, then one add or sub and one shift per multiplier bit
	localparam int DoneEdges = 2 * `MUL_STEPS + 1;
	localparam int NumLoadChecks = 11;
	localparam int LoadCycles = 2;
	// 8 corners, 24 random, 4 held chains of two multiplies each
	localparam int NumMultiplies = 40;
	localparam int OpCycles = 22;
	localparam int TimeoutCycles =
		2 * (ResetCycles + NumLoadChecks * LoadCycles + NumMultiplies * OpCycles);

	logic                  Clk;
	logic                  rstN;
	logic [`MUL_WIDTH-1:0] S;
	logic                  Run;
	logic                  ClearALoadB;
	logic [`MUL_WIDTH-1:0] Aval;
	logic [`MUL_WIDTH-1:0] Bval;
	logic                  X;
	logic [`SEG_WIDTH-1:0] AhexU;
	logic [`SEG_WIDTH-1:0] AhexL;
	logic [`SEG_WIDTH-1:0] BhexU;
	logic [`SEG_WIDTH-1:0] BhexL;

	// Expected register contents
	logic [`MUL_WIDTH-1:0] modelA;
	logic [`MUL_WIDTH-1:0] modelB;
	logic                  modelX;

	logic [31:0] lcgState;
	bit          checkReq;
	int          errorCount;
	int          checkCount;
	int          cycleCount;

	signedMultiplier uut
	(
		.Clk         (Clk),
		.rstN        (rstN),
		.S           (S),
		.Run         (Run),
		.ClearALoadB (ClearALoadB),
		.Aval        (Aval),
		.Bval        (Bval),
		.X           (X),
		.AhexU       (AhexU),
		.AhexL       (AhexL),
		.BhexU       (BhexU),
		.BhexL       (BhexL)
	);

	initial
	begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	// Signed product of two signed operands
	function automatic logic [2*`MUL_WIDTH-1:0] refProduct
	(
		input logic signed [`MUL_WIDTH-1:0] a,
		input logic signed [`MUL_WIDTH-1:0] b
	);
		logic signed [2*`MUL_WIDTH-1:0] p;
		p = a * b;
		return p;
	endfunction

	// Active-low segments with bit 0 as segment a
	function automatic logic [`SEG_WIDTH-1:0] hexPattern(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'hA: return 7'h08;
			4'hB: return 7'h03;
			4'hC: return 7'h46;
			4'hD: return 7'h21;
			4'hE: return 7'h06;
			default: return 7'h0E;
		endcase
	endfunction

	// LCG step with the upper-middle bits as the operand
	function automatic logic [`MUL_WIDTH-1:0] randByte();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[23:16];
	endfunction

	task automatic checkValue
	(
		input string       name,
		input logic [15:0] expected,
		input logic [15:0] actual
	);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("mismatch at %0d ns: %s expected %h, actual %h",
				$time, name, expected, actual);
		end
	endtask

	// Compare process woken by the stimulus at a falling edge
	initial
	begin
		forever
		begin
			wait (checkReq);
			checkValue("Aval", 16'(modelA), 16'(Aval));
			checkValue("Bval", 16'(modelB), 16'(Bval));
			checkValue("X", 16'(modelX), 16'(X));
			checkValue("AhexU", 16'(hexPattern(modelA[7:4])), 16'(AhexU));
			checkValue("AhexL", 16'(hexPattern(modelA[3:0])), 16'(AhexL));
			checkValue("BhexU", 16'(hexPattern(modelB[7:4])), 16'(BhexU));
			checkValue("BhexL", 16'(hexPattern(modelB[3:0])), 16'(BhexL));
			checkReq = 1'b0;
		end
	end

	task automatic requestCheck();
		checkReq = 1'b1;
		wait (checkReq == 1'b0);
	endtask

	// One cycle of ClearALoadB in idle
	task automatic loadB(input logic [`MUL_WIDTH-1:0] value);
		@(negedge Clk);
		S           = value;
		Run         = 1'b0;
		ClearALoadB = 1'b1;
		@(negedge Clk);
		ClearALoadB = 1'b0;
		modelA      = '0;
		modelB      = value;
		modelX      = 1'b0;
		requestCheck();
	endtask

	// Product is ready DoneEdges edges after the one that samples Run
	task automatic multiplyBy(input logic [`MUL_WIDTH-1:0] value);
		logic [2*`MUL_WIDTH-1:0] product;
		@(negedge Clk);
		S   = value;
		Run = 1'b1;
		repeat (DoneEdges + 1) @(posedge Clk);
		@(negedge Clk);
		product = refProduct(value, modelB);
		modelA  = product[2*`MUL_WIDTH-1:`MUL_WIDTH];
		modelB  = product[`MUL_WIDTH-1:0];
		modelX  = modelA[`MUL_WIDTH-1];
		requestCheck();
	endtask

	// Done state sees Run low and goes back to idle
	task automatic releaseRun();
		@(negedge Clk);
		Run = 1'b0;
	endtask

	// Run stays high and the switches move while the registers hold
	task automatic holdRun(input int cycles);
		repeat (cycles)
		begin
			@(negedge Clk);
			S = randByte();
			requestCheck();
		end
	endtask

	task automatic runProduct(input logic [7:0] b, input logic [7:0] s);
		loadB(b);
		multiplyBy(s);
		releaseRun();
	endtask

	// Stimulus
	initial
	begin
		rstN        = 1'b0;
		S           = '0;
		Run         = 1'b0;
		ClearALoadB = 1'b0;
		lcgState    = 32'h6cdd473d;
		checkReq    = 1'b0;
		errorCount  = 0;
		checkCount  = 0;
		modelA      = '0;
		modelB      = '0;
		modelX      = 1'b0;

		repeat (ResetCycles) @(posedge Clk);
		@(negedge Clk);
		rstN = 1'b1;
		requestCheck();

		// Edge values first, then random switches
		loadB(8'h00);
		loadB(8'h7F);
		loadB(8'h80);
		loadB(8'hFF);
		loadB(8'h01);
		repeat (NumLoadChecks - 5) loadB(randByte());

		runProduct(8'h80, 8'h80);
		runProduct(8'h80, 8'h7F);
		runProduct(8'h7F, 8'h80);
		runProduct(8'h00, randByte());
		runProduct(randByte(), 8'h00);
		runProduct(8'hFF, 8'hFF);
		runProduct(8'h7F, 8'h7F);
		runProduct(8'h01, 8'h80);

		repeat (24) runProduct(randByte(), randByte());

		// Second multiply uses the previous low byte as B
		repeat (4)
		begin
			loadB(randByte());
			multiplyBy(randByte());
			holdRun(5);
			releaseRun();
			multiplyBy(randByte());
			releaseRun();
		end

		$display("errors: %0d, checks: %0d", errorCount, checkCount);
		if (errorCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Cycle limit
	initial
	begin
		cycleCount = 0;
		while (cycleCount < TimeoutCycles)
		begin
			@(posedge Clk);
			cycleCount++;
		end
		$display("timeout: run did not finish within %0d cycles", TimeoutCycles);
		$display("errors: %0d, checks: %0d", errorCount, checkCount);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- hdl/signedMultiplier.sv
`include "mul_params.svh"

// Signed 8x8 multiplier for the switch and button lab board
// Product ends up in A:B, X carries the sign of A between steps
module signedMultiplier
(
	input  logic                  Clk,
	input  logic                  rstN,
	input  logic [`MUL_WIDTH-1:0] S,
	input  logic                  Run,
	input  logic                  ClearALoadB,
	output logic [`MUL_WIDTH-1:0] Aval,
	output logic [`MUL_WIDTH-1:0] Bval,
	output logic                  X,
	output logic [`SEG_WIDTH-1:0] AhexU,
	output logic [`SEG_WIDTH-1:0] AhexL,
	output logic [`SEG_WIDTH-1:0] BhexU,
	output logic [`SEG_WIDTH-1:0] BhexL
);

	// Strobes from the sequencer
	logic         clearAX;
	logic         loadB;
	logic         loadAX;
	logic         shiftEn;
	mulPkg::aluOp op;

	// Adder result into A and X
	logic [`MUL_WIDTH-1:0] adderSum;
	logic                  adderMsb;

	// M is the multiplier bit currently at B's bottom
	mulControl controller
	(
		.Clk         (Clk),
		.rstN        (rstN),
		.Run         (Run),
		.ClearALoadB (ClearALoadB),
		.M           (Bval[0]),
		.clearAX     (clearAX),
		.loadB       (loadB),
		.loadAX      (loadAX),
		.shiftEn     (shiftEn),
		.op          (op)
	);

	addSub9 adderUnit
	(
		.a   (Aval),
		.s   (S),
		.op  (op),
		.sum (adderSum),
		.msb (adderMsb)
	);

	// A takes X at the top on a shift, so the shift is arithmetic
	shiftReg #(.Width(`MUL_WIDTH)) regA
	(
		.Clk     (Clk),
		.rstN    (rstN),
		.clear   (clearAX),
		.load    (loadAX),
		.shiftEn (shiftEn),
		.shiftIn (X),
		.d       (adderSum),
		.q       (Aval)
	);

	// B loads straight from the switches and takes A's low bit on a shift
	// B is never cleared except by reset
	shiftReg #(.Width(`MUL_WIDTH)) regB
	(
		.Clk     (Clk),
		.rstN    (rstN),
		.clear   (1'b0),
		.load    (loadB),
		.shiftEn (shiftEn),
		.shiftIn (Aval[0]),
		.d       (S),
		.q       (Bval)
	);

	// Extension flop that holds during shifts
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
			X <= 1'b0;
		else if (clearAX)
			X <= 1'b0;
		else if (loadAX)
			X <= adderMsb;
	end

	// Displays
	hexDriver hexAU (.nibble(Aval[7:4]), .segments(AhexU));
	hexDriver hexAL (.nibble(Aval[3:0]), .segments(AhexL));
	hexDriver hexBU (.nibble(Bval[7:4]), .segments(BhexU));
	hexDriver hexBL (.nibble(Bval[3:0]), .segments(BhexL));

endmodule

//--- hdl/mulControl.sv
`include "mul_params.svh"

// Sequencer for the signed shift-and-add multiply
// Run starts one pass of clear, add/shift pairs, sub, lastShift and done
// ClearALoadB in idle clears A and X and loads S into B
module mulControl
(
	input  logic         Clk,
	input  logic         rstN,
	input  logic         Run,
	input  logic         ClearALoadB,
	input  logic         M,
	output logic         clearAX,
	output logic         loadB,
	output logic         loadAX,
	output logic         shiftEn,
	output mulPkg::aluOp op
);

	localparam int CntWidth = $clog2(`MUL_STEPS);

	// Shift count at which the next step is the subtract
	localparam logic [CntWidth-1:0] LastAddCnt = CntWidth'(`MUL_STEPS - 2);

	mulPkg::ctrlState state;
	mulPkg::ctrlState nextState;

	// Counts completed shifts within one pass
	logic [CntWidth-1:0] stepCnt;

	// State and step counter
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state   <= mulPkg::idle;
			stepCnt <= '0;
		end
		else
		begin
			state <= nextState;
			if (state == mulPkg::clear)
			begin
				stepCnt <= '0;
			end
			else if (state == mulPkg::shift)
			begin
				stepCnt <= stepCnt + 1'b1;
			end
		end
	end

	// Next state
	always_comb
	begin
		nextState = state;
		unique case (state)
			mulPkg::idle:
			begin
				// Run wins over ClearALoadB
				if (Run)
				begin
					nextState = mulPkg::clear;
				end
			end
			mulPkg::clear:
			begin
				nextState = mulPkg::add;
			end
			mulPkg::add:
			begin
				nextState = mulPkg::shift;
			end
			mulPkg::shift:
			begin
				// After the seventh shift the sign bit of B is at M
				if (stepCnt == LastAddCnt)
					nextState = mulPkg::sub;
				else
					nextState = mulPkg::add;
			end
			mulPkg::sub:
			begin
				nextState = mulPkg::lastShift;
			end
			mulPkg::lastShift:
			begin
				nextState = mulPkg::done;
			end
			mulPkg::done:
			begin
				// Hold the product until Run drops
				if (!Run)
				begin
					nextState = mulPkg::idle;
				end
			end
			default:
			begin
				nextState = mulPkg::idle;
			end
		endcase
	end

	// Strobes
	always_comb
	begin
		clearAX = 1'b0;
		loadB   = 1'b0;
		loadAX  = 1'b0;
		shiftEn = 1'b0;
		op      = mulPkg::opAdd;
		unique case (state)
			mulPkg::idle:
			begin
				// Load only while no multiply is being started
				clearAX = ClearALoadB && !Run;
				loadB   = ClearALoadB && !Run;
			end
			mulPkg::clear:
			begin
				clearAX = 1'b1;
			end
			mulPkg::add:
			begin
				loadAX = M;
			end
			mulPkg::sub:
			begin
				loadAX = M;
				op     = mulPkg::opSub;
			end
			mulPkg::shift, mulPkg::lastShift:
			begin
				shiftEn = 1'b1;
			end
			default:
			begin
				// done keeps every strobe off
			end
		endcase
	end

endmodule

//--- hdl/addSub9.sv
`include "mul_params.svh"

// Adder/subtractor one bit wider than the operands
// The extra bit feeds the X flop so the partial product keeps its sign
module addSub9
(
	input  logic [`MUL_WIDTH-1:0] a,
	input  logic [`MUL_WIDTH-1:0] s,
	input  mulPkg::aluOp          op,
	output logic [`MUL_WIDTH-1:0] sum,
	output logic                  msb
);

	localparam int ExtWidth = `MUL_WIDTH + 1;

	logic [ExtWidth-1:0] aExt;
	logic [ExtWidth-1:0] sExt;
	logic [ExtWidth-1:0] sOperand;
	logic                carryIn;
	logic [ExtWidth-1:0] result;

	// Sign extension by one bit
	assign aExt = {a[`MUL_WIDTH-1], a};
	assign sExt = {s[`MUL_WIDTH-1], s};

	// Two's complement subtract inverts the operand and adds one through the carry
	assign carryIn  = (op == mulPkg::opSub);
	assign sOperand = carryIn ? ~sExt : sExt;

	assign result = aExt + sOperand + ExtWidth'(carryIn);

	// Low bits go to A, top bit goes to X
	assign sum = result[`MUL_WIDTH-1:0];
	assign msb = result[ExtWidth-1];

endmodule

//--- hdl/shiftReg.sv
// Register with clear, parallel load and right shift
// Priority is clear, then load, then shift
module shiftReg
#(
	parameter int Width = 8
)
(
	input  logic             Clk,
	input  logic             rstN,
	input  logic             clear,
	input  logic             load,
	input  logic             shiftEn,
	input  logic             shiftIn,
	input  logic [Width-1:0] d,
	output logic [Width-1:0] q
);

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			q <= '0;
		end
		else if (clear)
		begin
			q <= '0;
		end
		else if (load)
		begin
			q <= d;
		end
		else if (shiftEn)
		begin
			// Serial input enters at the top, bit 0 drops out
			q <= {shiftIn, q[Width-1:1]};
		end
	end

endmodule

//--- hdl/hexDriver.sv
`include "mul_params.svh"

// Nibble to seven-segment decoder
// Active-low pattern with bit 0 as segment a up to bit 6 as segment g
module hexDriver
(
	input  logic [3:0]            nibble,
	output logic [`SEG_WIDTH-1:0] segments
);

	always_comb
	begin
		unique case (nibble)
			4'h0: segments = 7'h40;
			4'h1: segments = 7'h79;
			4'h2: segments = 7'h24;
			4'h3: segments = 7'h30;
			4'h4: segments = 7'h19;
			4'h5: segments = 7'h12;
			4'h6: segments = 7'h02;
			4'h7: segments = 7'h78;
			4'h8: segments = 7'h00;
			4'h9: segments = 7'h10;
			// Letters with b and d shown lower case
			4'hA: segments = 7'h08;
			4'hB: segments = 7'h03;
			4'hC: segments = 7'h46;
			4'hD: segments = 7'h21;
			4'hE: segments = 7'h06;
			4'hF: segments = 7'h0E;
			default: segments = 7'h7F;
		endcase
	end

endmodule

//--- hdl/mulPkg.sv
package mulPkg;

	// Sequencer states
	// idle waits for Run, and also handles ClearALoadB
	// clear zeroes A and X before the first step
	// add and shift alternate for the first MUL_STEPS-1 bits
	// sub replaces add for the sign bit of B
	// lastShift is the shift that follows sub
	// done holds until Run is released
	typedef enum logic [2:0]
	{
		idle,
		clear,
		add,
		shift,
		sub,
		lastShift,
		done
	} ctrlState;

	// Adder operation
	// opSub is needed on the last step since B's top bit has negative weight
	typedef enum logic
	{
		opAdd,
		opSub
	} aluOp;

endpackage

//--- hdl/mul_params.svh
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// Operand width of multiplicand S and multiplier B
`define MUL_WIDTH 8

// Add/shift pairs per multiplication with one per multiplier bit
`define MUL_STEPS `MUL_WIDTH

// Seven-segment pattern width for segments a to g
`define SEG_WIDTH 7

`endif
